// ==== Bender.yml ====
package:
  name: smem_switch

sources:
  - hdl/smem_config_pkg.sv
  - hdl/smem_types_pkg.sv
  - hdl/smem_bus_if.sv
  - hdl/stream_switch.sv
  - hdl/stream_arb.sv
  - hdl/smem_switch.sv
  - hdl/smem_bank.sv
  - hdl/smem_top.sv
  - target: simulation
    files:
      - verification/smem_assert.sv
      - verification/smem_tb.sv

// ==== hdl/smem_bank.sv ====
`timescale 1ns/10ps

module smem_bank #(
    parameter int BANK_WORDS = smem_config_pkg::BANK_WORDS
) (
    input logic        clk,
    input logic        reset,
    smem_req_if.slave  req,
    smem_rsp_if.master rsp
);

    import smem_types_pkg::*;

    localparam int IDX_W     = $clog2(BANK_WORDS);
    localparam int TAG_W     = $bits(req.tag);
    localparam int NUM_BYTES = $bits(byteen_t);

    data_t            mem [BANK_WORDS];
    data_t            q_data [2];
    logic [TAG_W-1:0] q_tag [2];
    logic             wr_ptr;
    logic             rd_ptr;
    logic [1:0]       count;
    logic [IDX_W-1:0] idx;
    logic             accept;
    logic             push;
    logic             pop;

    assign idx    = req.addr[IDX_W-1:0];
    assign accept = req.valid && req.ready;
    assign push   = accept && !req.rw;
    assign pop    = rsp.valid && rsp.ready;

    // One free slot, or the only entry leaves this cycle.
    assign req.ready = (count == 2'd0) || ((count == 2'd1) && rsp.ready);

    always_ff @(posedge clk) begin
        if (accept && req.rw) begin
            for (int b = 0; b < NUM_BYTES; b++) begin
                if (req.byteen[b]) begin
                    mem[idx][8*b +: 8] <= req.data[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            q_data[wr_ptr] <= mem[idx];
            q_tag[wr_ptr]  <= req.tag;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr <= !wr_ptr;
            end
            if (pop) begin
                rd_ptr <= !rd_ptr;
            end
            case ({push, pop})
                2'b10:   count <= count + 2'd1;
                2'b01:   count <= count - 2'd1;
                default: count <= count;
            endcase
        end
    end

    assign rsp.valid = (count != 2'd0);
    assign rsp.data  = q_data[rd_ptr];
    assign rsp.tag   = q_tag[rd_ptr];

endmodule

// ==== hdl/smem_bus_if.sv ====
`timescale 1ns/10ps

interface smem_req_if #(
    parameter int TAG_W = $bits(smem_types_pkg::tag_t)
);
    import smem_types_pkg::*;

    logic             valid;
    logic             ready;
    logic             rw;
    word_addr_t       addr;
    byteen_t          byteen;
    data_t            data;
    logic [TAG_W-1:0] tag;

    modport master (
        output valid,
        output rw,
        output addr,
        output byteen,
        output data,
        output tag,
        input  ready
    );

    modport slave (
        input  valid,
        input  rw,
        input  addr,
        input  byteen,
        input  data,
        input  tag,
        output ready
    );

endinterface

interface smem_rsp_if #(
    parameter int TAG_W = $bits(smem_types_pkg::tag_t)
);
    import smem_types_pkg::*;

    logic             valid;
    logic             ready;
    data_t            data;
    logic [TAG_W-1:0] tag;

    modport master (
        output valid,
        output data,
        output tag,
        input  ready
    );

    modport slave (
        input  valid,
        input  data,
        input  tag,
        output ready
    );

endinterface

// ==== hdl/smem_config_pkg.sv ====
package smem_config_pkg;

    // Number of banks behind the switch.
    localparam int NUM_REQS = 2;

    // Bytes per data word.
    localparam int DATA_SIZE = 4;

    // Requester tag and the bank selector inside it.
    localparam int TAG_WIDTH   = 8;
    localparam int TAG_SEL_IDX = 0;

    // Words held by each bank.
    localparam int BANK_WORDS = 64;

    // Widths derived from the sizes above.
    localparam int ADDR_WIDTH     = 32 - $clog2(DATA_SIZE);
    localparam int DATA_WIDTH     = 8 * DATA_SIZE;
    localparam int BANK_TAG_WIDTH = TAG_WIDTH - $clog2(NUM_REQS);

endpackage

// ==== hdl/smem_switch.sv ====
`timescale 1ns/10ps

module smem_switch #(
    parameter int NUM_REQS    = smem_config_pkg::NUM_REQS,
    parameter int TAG_SEL_IDX = smem_config_pkg::TAG_SEL_IDX
) (
    input logic        clk,
    input logic        reset,
    smem_req_if.slave  req_in,
    smem_rsp_if.master rsp_in,
    smem_req_if.master req_out [NUM_REQS],
    smem_rsp_if.slave  rsp_out [NUM_REQS]
);

    import smem_types_pkg::*;

    localparam int SEL_W     = $clog2(NUM_REQS);
    localparam int TAG_W     = $bits(tag_t);
    localparam int TAG_OUT_W = TAG_W - SEL_W;
    localparam int REQ_DATAW = TAG_OUT_W + $bits(word_addr_t) + 1 + $bits(byteen_t)
                               + $bits(data_t);
    localparam int RSP_DATAW = TAG_W + $bits(data_t);

    // Drop the selector bits and close the gap.
    function automatic logic [TAG_OUT_W-1:0] remove_sel(input logic [TAG_W-1:0] tag);
        logic [TAG_OUT_W-1:0] res;
        for (int b = 0; b < TAG_OUT_W; b++) begin
            res[b] = (b < TAG_SEL_IDX) ? tag[b] : tag[b + SEL_W];
        end
        return res;
    endfunction

    // Reopen the gap and put the bank number back.
    function automatic logic [TAG_W-1:0] insert_sel(input logic [TAG_OUT_W-1:0] tag,
                                                    input logic [SEL_W-1:0]     sel);
        logic [TAG_W-1:0] res;
        for (int b = 0; b < TAG_W; b++) begin
            if (b < TAG_SEL_IDX) begin
                res[b] = tag[b];
            end else if (b < TAG_SEL_IDX + SEL_W) begin
                res[b] = sel[b - TAG_SEL_IDX];
            end else begin
                res[b] = tag[b - SEL_W];
            end
        end
        return res;
    endfunction

    logic [SEL_W-1:0]                   req_sel;
    logic [REQ_DATAW-1:0]               req_data;
    logic [NUM_REQS-1:0]                req_valid_out;
    logic [NUM_REQS-1:0]                req_ready_out;
    logic [NUM_REQS-1:0][REQ_DATAW-1:0] req_data_out;
    logic [NUM_REQS-1:0]                rsp_valid_in;
    logic [NUM_REQS-1:0]                rsp_ready_in;
    logic [NUM_REQS-1:0][RSP_DATAW-1:0] rsp_data_in;
    logic [RSP_DATAW-1:0]               rsp_data;

    assign req_sel  = req_in.tag[TAG_SEL_IDX +: SEL_W];
    assign req_data = {remove_sel(req_in.tag), req_in.addr, req_in.rw,
                       req_in.byteen, req_in.data};

    stream_switch #(
        .NUM_OUTPUTS (NUM_REQS),
        .DATAW       (REQ_DATAW)
    ) req_switch (
        .clk       (clk),
        .reset     (reset),
        .sel_in    (req_sel),
        .valid_in  (req_in.valid),
        .ready_in  (req_in.ready),
        .data_in   (req_data),
        .valid_out (req_valid_out),
        .ready_out (req_ready_out),
        .data_out  (req_data_out)
    );

    for (genvar j = 0; j < NUM_REQS; j++) begin : g_bank
        assign req_out[j].valid = req_valid_out[j];
        assign {req_out[j].tag, req_out[j].addr, req_out[j].rw,
                req_out[j].byteen, req_out[j].data} = req_data_out[j];
        assign req_ready_out[j] = req_out[j].ready;

        assign rsp_valid_in[j]  = rsp_out[j].valid;
        assign rsp_data_in[j]   = {insert_sel(rsp_out[j].tag, SEL_W'(j)), rsp_out[j].data};
        assign rsp_out[j].ready = rsp_ready_in[j];
    end

    stream_arb #(
        .NUM_INPUTS (NUM_REQS),
        .DATAW      (RSP_DATAW)
    ) rsp_arb (
        .clk       (clk),
        .reset     (reset),
        .valid_in  (rsp_valid_in),
        .ready_in  (rsp_ready_in),
        .data_in   (rsp_data_in),
        .valid_out (rsp_in.valid),
        .ready_out (rsp_in.ready),
        .data_out  (rsp_data)
    );

    assign {rsp_in.tag, rsp_in.data} = rsp_data;

endmodule

// ==== hdl/smem_top.sv ====
`timescale 1ns/10ps

module smem_top #(
    parameter int NUM_REQS    = smem_config_pkg::NUM_REQS,
    parameter int TAG_SEL_IDX = smem_config_pkg::TAG_SEL_IDX,
    parameter int BANK_WORDS  = smem_config_pkg::BANK_WORDS
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       req_valid,
    output logic                       req_ready,
    input  logic                       req_rw,
    input  smem_types_pkg::word_addr_t req_addr,
    input  smem_types_pkg::byteen_t    req_byteen,
    input  smem_types_pkg::data_t      req_data,
    input  smem_types_pkg::tag_t       req_tag,
    output logic                       rsp_valid,
    input  logic                       rsp_ready,
    output smem_types_pkg::data_t      rsp_data,
    output smem_types_pkg::tag_t       rsp_tag
);

    import smem_types_pkg::*;

    // Banks see the tag with the selector removed.
    localparam int BANK_TAG_W = $bits(tag_t) - $clog2(NUM_REQS);

    smem_req_if #(.TAG_W($bits(tag_t))) req_if ();
    smem_rsp_if #(.TAG_W($bits(tag_t))) rsp_if ();
    smem_req_if #(.TAG_W(BANK_TAG_W))   bank_req_if [NUM_REQS] ();
    smem_rsp_if #(.TAG_W(BANK_TAG_W))   bank_rsp_if [NUM_REQS] ();

    assign req_if.valid  = req_valid;
    assign req_if.rw     = req_rw;
    assign req_if.addr   = req_addr;
    assign req_if.byteen = req_byteen;
    assign req_if.data   = req_data;
    assign req_if.tag    = req_tag;
    assign req_ready     = req_if.ready;

    assign rsp_valid    = rsp_if.valid;
    assign rsp_data     = rsp_if.data;
    assign rsp_tag      = rsp_if.tag;
    assign rsp_if.ready = rsp_ready;

    smem_switch #(
        .NUM_REQS    (NUM_REQS),
        .TAG_SEL_IDX (TAG_SEL_IDX)
    ) switch_inst (
        .clk     (clk),
        .reset   (reset),
        .req_in  (req_if),
        .rsp_in  (rsp_if),
        .req_out (bank_req_if),
        .rsp_out (bank_rsp_if)
    );

    for (genvar i = 0; i < NUM_REQS; i++) begin : g_bank
        smem_bank #(
            .BANK_WORDS (BANK_WORDS)
        ) bank_inst (
            .clk   (clk),
            .reset (reset),
            .req   (bank_req_if[i]),
            .rsp   (bank_rsp_if[i])
        );
    end

endmodule

// ==== hdl/smem_types_pkg.sv ====
package smem_types_pkg;

    import smem_config_pkg::*;

    // Word address, byte offset already stripped.
    typedef logic [ADDR_WIDTH-1:0] word_addr_t;

    // One data word.
    typedef logic [DATA_WIDTH-1:0] data_t;

    // One enable bit per byte of a word.
    typedef logic [DATA_SIZE-1:0] byteen_t;

    // Tag as issued by the requester.
    typedef logic [TAG_WIDTH-1:0] tag_t;

    // Tag seen by a bank, selector removed.
    typedef logic [BANK_TAG_WIDTH-1:0] bank_tag_t;

endpackage

// ==== hdl/stream_arb.sv ====
`timescale 1ns/10ps

module stream_arb #(
    parameter int NUM_INPUTS = 2,
    parameter int DATAW      = 8
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [NUM_INPUTS-1:0]            valid_in,
    output logic [NUM_INPUTS-1:0]            ready_in,
    input  logic [NUM_INPUTS-1:0][DATAW-1:0] data_in,
    output logic                             valid_out,
    input  logic                             ready_out,
    output logic [DATAW-1:0]                 data_out
);

    localparam int IDX_W = $clog2(NUM_INPUTS);

    typedef enum logic {
        EMPTY,
        FULL
    } arb_state_t;

    arb_state_t       state;
    logic [IDX_W-1:0] rr_ptr;
    logic [IDX_W-1:0] grant_idx;
    logic             grant_valid;
    logic             can_load;
    logic             load;
    logic [DATAW-1:0] data_q;

    // Output stage takes a new entry when empty or draining.
    assign can_load = (state == EMPTY) || ready_out;
    assign load     = grant_valid && can_load;

    // Walk inputs from the pointer; ready goes to those not blocked earlier.
    always_comb begin
        logic blocked;
        int   idx;
        blocked     = 1'b0;
        grant_idx   = '0;
        grant_valid = 1'b0;
        ready_in    = '0;
        for (int k = 0; k < NUM_INPUTS; k++) begin
            idx = (int'(rr_ptr) + k) % NUM_INPUTS;
            ready_in[idx] = can_load && !blocked;
            if (valid_in[idx] && !blocked) begin
                grant_idx   = IDX_W'(idx);
                grant_valid = 1'b1;
            end
            blocked = blocked || valid_in[idx];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= EMPTY;
            rr_ptr <= '0;
        end else begin
            if (load) begin
                state <= FULL;
            end else if (ready_out) begin
                state <= EMPTY;
            end
            // Next search starts just past the winner.
            if (load) begin
                if (grant_idx == IDX_W'(NUM_INPUTS - 1)) begin
                    rr_ptr <= '0;
                end else begin
                    rr_ptr <= grant_idx + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            data_q <= data_in[grant_idx];
        end
    end

    assign valid_out = (state == FULL);
    assign data_out  = data_q;

endmodule

// ==== hdl/stream_switch.sv ====
`timescale 1ns/10ps

module stream_switch #(
    parameter int NUM_OUTPUTS = 2,
    parameter int DATAW       = 8
) (
    input  logic                              clk,
    input  logic                              reset,
    input  logic [$clog2(NUM_OUTPUTS)-1:0]    sel_in,
    input  logic                              valid_in,
    output logic                              ready_in,
    input  logic [DATAW-1:0]                  data_in,
    output logic [NUM_OUTPUTS-1:0]            valid_out,
    input  logic [NUM_OUTPUTS-1:0]            ready_out,
    output logic [NUM_OUTPUTS-1:0][DATAW-1:0] data_out
);

    logic accept;

    // Stall only if the selected stage is full and not draining.
    assign ready_in = !valid_out[sel_in] || ready_out[sel_in];
    assign accept   = valid_in && ready_in;

    for (genvar i = 0; i < NUM_OUTPUTS; i++) begin : g_out
        logic             load;
        logic             valid_r;
        logic [DATAW-1:0] data_r;

        assign load = accept && (sel_in == i);

        always_ff @(posedge clk) begin
            if (reset) begin
                valid_r <= 1'b0;
            end else if (load) begin
                valid_r <= 1'b1;
            end else if (ready_out[i]) begin
                valid_r <= 1'b0;
            end
        end

        always_ff @(posedge clk) begin
            if (load) begin
                data_r <= data_in;
            end
        end

        assign valid_out[i] = valid_r;
        assign data_out[i]  = data_r;
    end

endmodule

// ==== src.f ====
hdl/smem_config_pkg.sv
hdl/smem_types_pkg.sv
hdl/smem_bus_if.sv
hdl/stream_switch.sv
hdl/stream_arb.sv
hdl/smem_switch.sv
hdl/smem_bank.sv
hdl/smem_top.sv
verification/smem_assert.sv
verification/smem_tb.sv

// ==== verification/smem_assert.sv ====
`timescale 1ns/10ps

module smem_assert #(
    parameter int NUM_REQS  = 2,
    parameter int REQ_DATAW = 8,
    parameter int RSP_DATAW = 8
) (
    input logic                               clk,
    input logic                               reset,
    input logic [NUM_REQS-1:0]                req_valid,
    input logic [NUM_REQS-1:0]                req_ready,
    input logic [NUM_REQS-1:0][REQ_DATAW-1:0] req_data,
    input logic                               rsp_valid,
    input logic                               rsp_ready,
    input logic [RSP_DATAW-1:0]               rsp_data
);

    int fail_count = 0;

    // Bank request stages.
    for (genvar i = 0; i < NUM_REQS; i++) begin : g_req
        assert property (@(posedge clk) disable iff (reset)
            req_valid[i] && !req_ready[i] |=> req_valid[i])
        else begin
            $error("bank request valid dropped before handshake");
            fail_count++;
        end

        assert property (@(posedge clk) disable iff (reset)
            req_valid[i] && !req_ready[i] |=> $stable(req_data[i]))
        else begin
            $error("bank request payload changed while stalled");
            fail_count++;
        end
    end

    // Response output stage.
    assert property (@(posedge clk) disable iff (reset)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_data))
    else begin
        $error("response valid or payload changed while stalled");
        fail_count++;
    end

    assert property (@(posedge clk) reset |=> !rsp_valid && (req_valid == '0))
    else begin
        $error("switch valids high after reset");
        fail_count++;
    end

endmodule

bind smem_switch smem_assert #(
    .NUM_REQS  (NUM_REQS),
    .REQ_DATAW (REQ_DATAW),
    .RSP_DATAW (RSP_DATAW)
) handshake_check (
    .clk       (clk),
    .reset     (reset),
    .req_valid (req_valid_out),
    .req_ready (req_ready_out),
    .req_data  (req_data_out),
    .rsp_valid (rsp_in.valid),
    .rsp_ready (rsp_in.ready),
    .rsp_data  (rsp_data)
);

// ==== verification/smem_tb.sv ====
`timescale 1ns/10ps

module smem_tb;

    import smem_config_pkg::*;
    import smem_types_pkg::*;

    localparam int SEL_W      = $clog2(NUM_REQS);
    localparam int IDX_W      = $clog2(BANK_WORDS);
    localparam int NUM_RANDOM = 300;
    // Fill writes plus random requests, a few cycles each, times four.
    localparam int TIMEOUT_CYCLES = 4000;

    logic       clk;
    logic       reset;
    logic       req_valid;
    logic       req_ready;
    logic       req_rw;
    word_addr_t req_addr;
    byteen_t    req_byteen;
    data_t      req_data;
    tag_t       req_tag;
    logic       rsp_valid;
    logic       rsp_ready;
    data_t      rsp_data;
    tag_t       rsp_tag;

    int    seed = 32'hc769_8483;
    int    cycles = 0;
    logic  throttle_rsp = 1'b0;
    logic  writes_only = 1'b0;
    logic  tag_ok = 1'b1;
    logic  data_ok = 1'b1;
    data_t model_mem [NUM_REQS*BANK_WORDS];
    tag_t  exp_tag [NUM_REQS][$];
    data_t exp_data [NUM_REQS][$];

    smem_top #(
        .NUM_REQS    (NUM_REQS),
        .TAG_SEL_IDX (TAG_SEL_IDX),
        .BANK_WORDS  (BANK_WORDS)
    ) smem_top_inst (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req_rw     (req_rw),
        .req_addr   (req_addr),
        .req_byteen (req_byteen),
        .req_data   (req_data),
        .req_tag    (req_tag),
        .rsp_valid  (rsp_valid),
        .rsp_ready  (rsp_ready),
        .rsp_data   (rsp_data),
        .rsp_tag    (rsp_tag)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic report_failure(input string msg);
        $display("FAILED %0t: %s", $time, msg);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: reads still outstanding after %0d cycles", TIMEOUT_CYCLES);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    end

    assert property (@(posedge clk) disable iff (reset) rsp_valid |-> tag_ok)
    else report_failure("rsp_tag matches no outstanding read of its bank");

    assert property (@(posedge clk) disable iff (reset) rsp_valid |-> data_ok)
    else report_failure("rsp_data differs from the model word");

    assert property (@(posedge clk) reset |=> !rsp_valid && req_ready)
    else report_failure("rsp_valid high or req_ready low after reset");

    assert property (@(posedge clk) disable iff (reset) writes_only |-> !rsp_valid)
    else report_failure("response seen during a write-only run");

    assert property (@(posedge clk) smem_top_inst.switch_inst.handshake_check.fail_count == 0)
    else report_failure("handshake rule broken inside smem_switch");

    // Inputs and outputs are settled here, so this is what the next edge sees.
    always @(negedge clk) begin
        int unsigned rb;
        int unsigned qb;
        int unsigned widx;
        tag_ok  = 1'b1;
        data_ok = 1'b1;
        if (!reset && rsp_valid) begin
            rb      = rsp_tag[TAG_SEL_IDX +: SEL_W];
            tag_ok  = (exp_tag[rb].size() != 0) && (exp_tag[rb][0] == rsp_tag);
            data_ok = tag_ok && (exp_data[rb][0] == rsp_data);
            if (rsp_ready && exp_tag[rb].size() != 0) begin
                void'(exp_tag[rb].pop_front());
                void'(exp_data[rb].pop_front());
            end
        end
        if (!reset && req_valid && req_ready) begin
            qb   = req_tag[TAG_SEL_IDX +: SEL_W];
            widx = qb * BANK_WORDS + req_addr[IDX_W-1:0];
            if (req_rw) begin
                for (int b = 0; b < $bits(byteen_t); b++) begin
                    if (req_byteen[b]) begin
                        model_mem[widx][8*b +: 8] = req_data[8*b +: 8];
                    end
                end
            end else begin
                exp_tag[qb].push_back(req_tag);
                exp_data[qb].push_back(model_mem[widx]);
            end
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
        rsp_ready = throttle_rsp ? (($random(seed) & 3) != 0) : 1'b1;
    endtask

    task automatic send_request(input logic rw, input word_addr_t addr,
                                input byteen_t byteen, input data_t data, input tag_t tag);
        logic accepted;
        req_valid  = 1'b1;
        req_rw     = rw;
        req_addr   = addr;
        req_byteen = byteen;
        req_data   = data;
        req_tag    = tag;
        accepted   = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            accepted = req_ready;
            next_cycle();
        end
        req_valid = 1'b0;
    endtask

    function automatic int outstanding();
        int n;
        n = 0;
        for (int b = 0; b < NUM_REQS; b++) begin
            n += exp_tag[b].size();
        end
        return n;
    endfunction

    initial begin
        tag_t       tag;
        word_addr_t addr;
        req_valid  = 1'b0;
        req_rw     = 1'b0;
        req_addr   = '0;
        req_byteen = '0;
        req_data   = '0;
        req_tag    = '0;
        rsp_ready  = 1'b1;
        reset      = 1'b1;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;

        // Full-word writes to every word of every bank.
        writes_only = 1'b1;
        for (int w = 0; w < NUM_REQS * BANK_WORDS; w++) begin
            tag = $random(seed);
            tag[TAG_SEL_IDX +: SEL_W] = w / BANK_WORDS;
            addr = $random(seed);
            addr[IDX_W-1:0] = w % BANK_WORDS;
            send_request(1'b1, addr, '1, $random(seed), tag);
        end
        repeat (4) next_cycle();
        writes_only = 1'b0;

        // Mixed reads and partial writes under response back-pressure.
        throttle_rsp = 1'b1;
        for (int n = 0; n < NUM_RANDOM; n++) begin
            tag  = $random(seed);
            addr = $random(seed);
            if (($random(seed) & 3) == 0) begin
                send_request(1'b1, addr, $random(seed), $random(seed), tag);
            end else begin
                send_request(1'b0, addr, '0, $random(seed), tag);
            end
        end
        while (outstanding() != 0) begin
            next_cycle();
        end
        repeat (4) next_cycle();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule
